//--- Makefile
TOP := tb_clk_mgmt
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
hw/clk_mgmt_pkg.sv
hw/drp_regs.sv
hw/lock_monitor.sv
hw/clk_div_bank.sv
hw/clk_out_stage.sv
hw/clk_mgmt_top.sv
verification/clk_mgmt_props.sv
verification/tb_clk_mgmt.sv

//--- hw/clk_div_bank.sv
`timescale 1ns/1ps

module clk_div_bank (
  input  logic                      CLKIN1,
  input  logic                      reset,
  input  logic                      restart,
  input  clk_mgmt_pkg::ch_cfg_arr_t ch_cfg,
  output clk_mgmt_pkg::clk_bus_t    div_clk
);
  import clk_mgmt_pkg::*;

  logic [15:0] div_cnt   [num_ch];
  logic [15:0] div_limit [num_ch];  // 2^k - 1

  // ####################################################################
  // terminal count per channel
  // ####################################################################

  always_comb
  begin
    for (int i = 0; i < num_ch; i++)
      div_limit[i] = (16'd1 << ch_cfg[i].div_exp) - 16'd1;
  end

  // ####################################################################
  // toggle dividers
  // ####################################################################

  // all channels cleared together so edges stay aligned
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < num_ch; i++)
        div_cnt[i] <= '0;
      div_clk <= '0;
    end
    else if (restart)
    begin
      for (int i = 0; i < num_ch; i++)
        div_cnt[i] <= '0;
      div_clk <= '0;
    end
    else
    begin
      for (int i = 0; i < num_ch; i++)
      begin
        // >= covers a smaller div_exp written mid-count
        if (div_cnt[i] >= div_limit[i])
        begin
          div_cnt[i]     <= '0;
          div_clk.clk[i] <= ~div_clk.clk[i];
        end
        else
          div_cnt[i] <= div_cnt[i] + 16'd1;
      end
    end
  end

endmodule

//--- hw/clk_mgmt_pkg.sv
package clk_mgmt_pkg;

  // ####################################################################
  // sizes and reconfiguration port types
  // ####################################################################

  localparam int num_ch = 7;  // output channels

  typedef logic [6:0]  drp_addr_t;
  typedef logic [15:0] drp_data_t;

  // ####################################################################
  // register layouts
  // ####################################################################

  // channel word, addresses 0..6
  typedef struct packed {
    logic [7:0] spare;
    logic [3:0] phase;    // delay in CLKIN1 cycles
    logic [3:0] div_exp;  // toggle every 2^div_exp cycles
  } ch_cfg_t;

  // control word at addr_ctrl
  typedef struct packed {
    logic [13:0] spare;
    logic        pwrdwn;    // level, held until cleared
    logic        soft_rst;  // write 1 to restart, reads back 0
  } ctrl_cfg_t;

  // one stored word, decoded by address
  typedef union packed {
    ch_cfg_t   ch;
    ctrl_cfg_t ctrl;
    drp_data_t raw;
  } drp_word_u;

  localparam drp_addr_t addr_ctrl   = 7'd7;
  localparam drp_addr_t addr_status = 7'd8;  // bit 0 is locked

  // ####################################################################
  // clock buses
  // ####################################################################

  typedef struct packed {
    logic [num_ch-1:0] clk;  // one bit per channel
  } clk_bus_t;

  typedef ch_cfg_t [num_ch-1:0] ch_cfg_arr_t;

endpackage

//--- hw/clk_mgmt_top.sv
`timescale 1ns/1ps

module clk_mgmt_top #(
  parameter int lock_cycles = 15  // cycles from restart to locked
) (
  input  logic                    CLKIN1,
  input  logic                    reset,
  input  logic                    den,
  input  logic                    dwe,
  input  clk_mgmt_pkg::drp_addr_t daddr,
  input  clk_mgmt_pkg::drp_data_t di,
  output clk_mgmt_pkg::drp_data_t dout,
  output logic                    drdy,
  output logic                    locked,
  output clk_mgmt_pkg::clk_bus_t  clkout
);
  import clk_mgmt_pkg::*;

  ch_cfg_arr_t ch_cfg;
  clk_bus_t    div_clk;
  logic        pwrdwn;
  logic        cfg_write;
  logic        restart;

  // configuration registers
  drp_regs u_drp_regs (
    .CLKIN1    (CLKIN1),
    .reset     (reset),
    .den       (den),
    .dwe       (dwe),
    .daddr     (daddr),
    .di        (di),
    .locked    (locked),  // status readback
    .dout      (dout),
    .drdy      (drdy),
    .ch_cfg    (ch_cfg),
    .pwrdwn    (pwrdwn),
    .cfg_write (cfg_write)
  );

  lock_monitor #(
    .lock_cycles (lock_cycles)
  ) u_lock_monitor (
    .CLKIN1    (CLKIN1),
    .reset     (reset),
    .cfg_write (cfg_write),
    .pwrdwn    (pwrdwn),
    .locked    (locked),
    .restart   (restart)
  );

  clk_div_bank u_clk_div_bank (
    .CLKIN1  (CLKIN1),
    .reset   (reset),
    .restart (restart),
    .ch_cfg  (ch_cfg),
    .div_clk (div_clk)
  );

  // phase delay and lock masking
  clk_out_stage u_clk_out_stage (
    .CLKIN1  (CLKIN1),
    .reset   (reset),
    .locked  (locked),
    .ch_cfg  (ch_cfg),
    .div_clk (div_clk),
    .clkout  (clkout)
  );

endmodule

//--- hw/clk_out_stage.sv
`timescale 1ns/1ps

module clk_out_stage (
  input  logic                      CLKIN1,
  input  logic                      reset,
  input  logic                      locked,
  input  clk_mgmt_pkg::ch_cfg_arr_t ch_cfg,
  input  clk_mgmt_pkg::clk_bus_t    div_clk,
  output clk_mgmt_pkg::clk_bus_t    clkout
);
  import clk_mgmt_pkg::*;

  logic [14:0]       dly_line [num_ch];  // history of each divider output
  logic [15:0]       dly_taps [num_ch];  // 16 taps, tap 0 is live input
  logic [num_ch-1:0] phased;

  // delay lines, one shift per cycle
  always_ff @(posedge CLKIN1)
  begin
    for (int i = 0; i < num_ch; i++)
      dly_line[i] <= {dly_line[i][13:0], div_clk.clk[i]};
  end

  always_comb
  begin
    for (int i = 0; i < num_ch; i++)
    begin
      dly_taps[i] = {dly_line[i], div_clk.clk[i]};
      phased[i]   = dly_taps[i][ch_cfg[i].phase];  // phase + 1 after the flop
    end
  end

  // ####################################################################
  // lock mask
  // ####################################################################

  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
      clkout <= '0;
    else
      clkout.clk <= locked ? phased : '0;
  end

endmodule

//--- hw/drp_regs.sv
`timescale 1ns/1ps

module drp_regs (
  input  logic                      CLKIN1,
  input  logic                      reset,
  input  logic                      den,
  input  logic                      dwe,
  input  clk_mgmt_pkg::drp_addr_t   daddr,
  input  clk_mgmt_pkg::drp_data_t   di,
  input  logic                      locked,
  output clk_mgmt_pkg::drp_data_t   dout,
  output logic                      drdy,
  output clk_mgmt_pkg::ch_cfg_arr_t ch_cfg,
  output logic                      pwrdwn,
  output logic                      cfg_write
);
  import clk_mgmt_pkg::*;

  ctrl_cfg_t ctrl_q;
  drp_word_u wr_word;  // incoming data, viewed per address
  drp_word_u rd_word;  // readback source
  logic      ch_hit;
  logic      ctrl_hit;
  logic      wr_en;
  logic      rd_en;
  logic [2:0] ch_idx;

  assign ch_hit   = (daddr < drp_addr_t'(num_ch));
  assign ctrl_hit = (daddr == addr_ctrl);
  assign ch_idx   = daddr[2:0];
  assign wr_en    = den & dwe;
  assign rd_en    = den & ~dwe;
  assign wr_word  = di;

  // readback mux
  always_comb
  begin
    rd_word.raw = '0;
    if (ch_hit)
      rd_word.ch = ch_cfg[ch_idx];
    else if (ctrl_hit)
      rd_word.ctrl = ctrl_q;
    else if (daddr == addr_status)
      rd_word.raw = drp_data_t'(locked);  // unmapped stays zero
  end

  // ####################################################################
  // register file, written on the edge that raises drdy
  // ####################################################################

  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      ch_cfg <= '0;
      ctrl_q <= '0;
    end
    else if (wr_en)
    begin
      if (ch_hit)
        ch_cfg[ch_idx] <= wr_word.ch;
      else if (ctrl_hit)
      begin
        ctrl_q          <= wr_word.ctrl;
        ctrl_q.soft_rst <= 1'b0;  // pulse only, never stored
      end
    end
  end

  assign pwrdwn = ctrl_q.pwrdwn;

  // strobe response and restart request
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      drdy      <= 1'b0;
      dout      <= '0;
      cfg_write <= 1'b0;
    end
    else
    begin
      drdy      <= den;
      dout      <= rd_en ? rd_word.raw : '0;  // zero outside read drdy
      cfg_write <= wr_en & (ch_hit | (ctrl_hit & wr_word.ctrl.soft_rst));
    end
  end

endmodule

//--- hw/lock_monitor.sv
`timescale 1ns/1ps

module lock_monitor #(
  parameter int lock_cycles = 15
) (
  input  logic CLKIN1,
  input  logic reset,
  input  logic cfg_write,
  input  logic pwrdwn,
  output logic locked,
  output logic restart
);

  localparam int cnt_w = $clog2(lock_cycles + 1);

  logic [cnt_w-1:0] lock_cnt;
  logic             reload;
  logic             pwrdwn_q;  // previous cycle, for the rising edge

  assign reload = cfg_write | pwrdwn;  // pwrdwn keeps reloading

  // count down to zero, then hold
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
      lock_cnt <= cnt_w'(lock_cycles);
    else if (reload)
      lock_cnt <= cnt_w'(lock_cycles);
    else if (lock_cnt != '0)
      lock_cnt <= lock_cnt - 1'b1;
  end

  assign locked = (lock_cnt == '0);

  // one pulse per reload run so the dividers restart once
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      pwrdwn_q <= 1'b0;
      restart  <= 1'b0;
    end
    else
    begin
      pwrdwn_q <= pwrdwn;
      restart  <= cfg_write | (pwrdwn & ~pwrdwn_q);
    end
  end

endmodule

//--- verification/clk_mgmt_props.sv
`timescale 1ns/1ps

module clk_mgmt_props (
  input logic                   CLKIN1,
  input logic                   reset,
  input logic                   den,
  input logic                   drdy,
  input logic                   locked,
  input logic                   pwrdwn,
  input clk_mgmt_pkg::clk_bus_t clkout
);

  int assert_fails = 0;  // summed into the testbench error count

  // every strobe answered exactly one cycle later
  drdy_follows_den: assert property (
    @(posedge CLKIN1) disable iff (reset) drdy == $past(den))
  else
  begin
    assert_fails++;
    $error("drdy does not follow den by one cycle");
  end

  clkout_masked: assert property (
    @(posedge CLKIN1) disable iff (reset) !$past(locked) |-> clkout == '0)
  else
  begin
    assert_fails++;
    $error("clkout active although locked was low");
  end

  // power-down keeps the lock counter reloading
  no_lock_in_pwrdwn: assert property (
    @(posedge CLKIN1) disable iff (reset) $rose(locked) |-> !pwrdwn)
  else
  begin
    assert_fails++;
    $error("locked rose during power-down");
  end

endmodule

//--- verification/tb_clk_mgmt.sv
`timescale 1ns/1ps

module tb_clk_mgmt;
  import clk_mgmt_pkg::*;

  localparam int clk_period  = 40;
  localparam int lock_cycles = 15;
  localparam int win_len     = 96;  // output samples per window
  // reset, first lock, readback, division, phase, relock, power-down
  localparam int budget_cycles = 10 + 25 + 160 + 180 + 160 + 40 + 130;

  logic        CLKIN1;
  logic        reset;
  logic        den;
  logic        dwe;
  drp_addr_t   daddr;
  drp_data_t   di;
  drp_data_t   dout;
  logic        drdy;
  logic        locked;
  clk_bus_t    clkout;

  int          err_count;
  int          check_count;
  int          test_errs;
  clk_bus_t    win [win_len];

  clk_mgmt_top #(
    .lock_cycles (lock_cycles)
  ) u_clk_mgmt_top (
    .CLKIN1 (CLKIN1),
    .reset  (reset),
    .den    (den),
    .dwe    (dwe),
    .daddr  (daddr),
    .di     (di),
    .dout   (dout),
    .drdy   (drdy),
    .locked (locked),
    .clkout (clkout)
  );

  bind clk_mgmt_top clk_mgmt_props u_clk_mgmt_props (
    .CLKIN1 (CLKIN1),
    .reset  (reset),
    .den    (den),
    .drdy   (drdy),
    .locked (locked),
    .pwrdwn (pwrdwn),
    .clkout (clkout)
  );

  initial
  begin
    CLKIN1 = 1'b0;
    forever #(clk_period / 2) CLKIN1 = ~CLKIN1;
  end

  // twice the summed test budgets
  initial
  begin
    #(budget_cycles * 2 * clk_period);
    $display("watchdog expired after %0d cycles, a test never finished", budget_cycles * 2);
    $display("TEST FAILED");
    $finish;
  end

  // ####################################################################
  // compare tasks
  // ####################################################################

  task automatic check_data(string what, drp_data_t got, drp_data_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[FAIL] %0t ns %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bus(string what, clk_bus_t got, clk_bus_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[FAIL] %0t ns %s: got %b expected %b", $time, what, got.clk, exp.clk);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[FAIL] %0t ns %s: got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_error(string msg);
    err_count++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  // ####################################################################
  // reconfiguration port and lock helpers
  // ####################################################################

  task automatic drp_access(drp_addr_t addr, logic write, drp_data_t wdata,
                            output drp_data_t rdata);
    @(posedge CLKIN1);
    den   <= 1'b1;
    dwe   <= write;
    daddr <= addr;
    di    <= wdata;
    @(posedge CLKIN1);
    den <= 1'b0;
    dwe <= 1'b0;
    @(negedge CLKIN1);
    check_bit("drdy one cycle after den", drdy, 1'b1);
    rdata = dout;
  endtask

  task automatic drp_write(drp_addr_t addr, drp_data_t data);
    drp_data_t rd;
    drp_access(addr, 1'b1, data, rd);
    check_data("dout during write", rd, '0);  // only reads drive dout
  endtask

  task automatic drp_read(drp_addr_t addr, output drp_data_t data);
    drp_access(addr, 1'b0, '0, data);
  endtask

  task automatic wait_locked(logic level, int max_cycles);
    int n = 0;
    while (locked !== level && n < max_cycles)
    begin
      @(negedge CLKIN1);
      n++;
    end
    if (locked !== level)
      report_error($sformatf("locked did not reach %b within %0d cycles", level, max_cycles));
  endtask

  // counts cycles from the drop of locked to its return
  task automatic measure_relock(string what);
    int n = 0;
    wait_locked(1'b0, 4);
    while (!locked && n < lock_cycles + 8)
    begin
      @(negedge CLKIN1);
      n++;
      check_bus({what, ": clkout masked"}, clkout, '0);  // locked was low last cycle
    end
    check_data({what, ": cycles to lock"}, drp_data_t'(n), drp_data_t'(lock_cycles));
  endtask

  task automatic sample_window();
    repeat (24) @(negedge CLKIN1);  // flush history from before the restart
    for (int t = 0; t < win_len; t++)
    begin
      @(negedge CLKIN1);
      win[t] = clkout;
    end
  endtask

  // ####################################################################
  // directed tests
  // ####################################################################

  task automatic test_reset_lock();
    check_bit("locked in reset", locked, 1'b0);
    check_bus("clkout in reset", clkout, '0);
    check_bit("drdy in reset", drdy, 1'b0);
    @(posedge CLKIN1);
    reset <= 1'b0;
    @(negedge CLKIN1);
    measure_relock("reset release");
  endtask

  task automatic test_readback();
    drp_data_t words [num_ch + 1];
    drp_data_t rd;
    drp_addr_t unmapped [3];
    unmapped = '{7'd9, 7'd127, drp_addr_t'($urandom_range(126, 10))};
    for (int a = 0; a <= num_ch; a++)
    begin
      words[a] = drp_data_t'($urandom);
      if (a == num_ch)
        words[a][1] = 1'b0;  // keep power on
      drp_write(drp_addr_t'(a), words[a]);
    end
    words[num_ch][0] = 1'b0;  // soft_rst self-clears
    for (int a = 0; a <= num_ch; a++)
    begin
      drp_read(drp_addr_t'(a), rd);
      check_data($sformatf("readback addr %0d", a), rd, words[a]);
    end
    wait_locked(1'b1, lock_cycles + 8);
    drp_read(addr_status, rd);
    check_data("status when locked", rd, 16'h0001);
    drp_write(7'd0, words[0]);
    drp_read(addr_status, rd);
    check_data("status while relocking", rd, 16'h0000);
    foreach (unmapped[i])
    begin
      drp_read(unmapped[i], rd);
      check_data($sformatf("unmapped addr %0d", unmapped[i]), rd, '0);
    end
  endtask

  task automatic test_division();
    logic [3:0] k [num_ch];
    int last;
    int runs;
    for (int ch = 0; ch < num_ch; ch++)
    begin
      k[ch] = 4'($urandom_range(4, 0));
      drp_write(drp_addr_t'(ch), {8'h00, 4'($urandom_range(15, 0)), k[ch]});
    end
    wait_locked(1'b1, lock_cycles + 8);  // back-to-back writes keep it low
    sample_window();
    for (int ch = 0; ch < num_ch; ch++)
    begin
      last = -1;
      runs = 0;
      for (int t = 1; t < win_len; t++)
      begin
        if (win[t].clk[ch] != win[t - 1].clk[ch])
        begin
          if (last >= 0)
          begin
            check_data($sformatf("ch %0d run length, k %0d", ch, k[ch]),
                       drp_data_t'(t - last), drp_data_t'(1 << k[ch]));
            runs++;
          end
          last = t;
        end
      end
      if (runs < 2)
        report_error($sformatf("ch %0d toggled too rarely to measure its runs", ch));
    end
  endtask

  task automatic test_phase();
    int ch_a;
    int ch_b;
    int pa;
    int pb;
    int t2;
    int hits = 0;
    ch_a = $urandom_range(num_ch - 1, 0);
    ch_b = (ch_a + 1 + $urandom_range(num_ch - 2, 0)) % num_ch;
    pa   = $urandom_range(15, 0);
    pb   = $urandom_range(15, 0);
    drp_write(drp_addr_t'(ch_a), {8'h00, 4'(pa), 4'd4});  // period 32 exceeds any offset
    drp_write(drp_addr_t'(ch_b), {8'h00, 4'(pb), 4'd4});
    wait_locked(1'b1, lock_cycles + 8);
    sample_window();
    for (int t = 1; t < win_len; t++)
    begin
      t2 = t + pb - pa;
      if (win[t].clk[ch_a] && !win[t - 1].clk[ch_a] && t2 >= 1 && t2 < win_len)
      begin
        check_bit($sformatf("ch %0d rises %0d cycles after ch %0d", ch_b, pb - pa, ch_a),
                  win[t2].clk[ch_b] & ~win[t2 - 1].clk[ch_b], 1'b1);
        hits++;
      end
    end
    if (hits == 0)
      report_error("no rising edge pair fell inside the sample window");
  endtask

  task automatic test_relock();
    check_bit("locked before write", locked, 1'b1);
    drp_write(7'd2, {8'h00, 4'd3, 4'd1});
    measure_relock("channel write");
  endtask

  task automatic test_power_down();
    drp_data_t rd;
    drp_write(addr_ctrl, 16'h0002);
    wait_locked(1'b0, 4);
    @(negedge CLKIN1);
    repeat (40)
    begin
      @(negedge CLKIN1);
      check_bit("locked in power-down", locked, 1'b0);
      check_bus("clkout in power-down", clkout, '0);
    end
    drp_read(addr_ctrl, rd);
    check_data("control in power-down", rd, 16'h0002);
    drp_write(addr_ctrl, 16'h0000);
    measure_relock("power-down release");
    drp_write(addr_ctrl, 16'h0001);
    measure_relock("soft reset");
    drp_read(addr_ctrl, rd);
    check_data("control after soft reset", rd, 16'h0000);
  endtask

  task automatic report_test(string name);
    if (err_count == test_errs)
      $display("%-22s ok", name);
    else
      $display("%-22s %0d errors", name, err_count - test_errs);
    test_errs = err_count;
  endtask

  initial
  begin
    reset       = 1'b1;
    den         = 1'b0;
    dwe         = 1'b0;
    daddr       = '0;
    di          = '0;
    err_count   = 0;
    check_count = 0;
    test_errs   = 0;
    void'($urandom(21933));
    repeat (9) @(posedge CLKIN1);
    @(negedge CLKIN1);
    test_reset_lock();
    report_test("reset and first lock");
    test_readback();
    report_test("register readback");
    test_division();
    report_test("division");
    test_phase();
    report_test("phase");
    test_relock();
    report_test("relock on write");
    test_power_down();
    report_test("power-down, soft reset");
    err_count += u_clk_mgmt_top.u_clk_mgmt_props.assert_fails;
    $display("summary: 6 tests, %0d checks, %0d assertion failures, %0d errors",
             check_count, u_clk_mgmt_top.u_clk_mgmt_props.assert_fails, err_count);
    if (err_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
